//--- rtl/rvDefs.svh
// RV32I shared constants
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define XLEN    32
`define SHAMTW  5   // Shift amount bits

// Base opcodes
`define OP_LOAD   7'b0000011
`define OP_IMM    7'b0010011
`define OP_AUIPC  7'b0010111
`define OP_STORE  7'b0100011
`define OP_REG    7'b0110011
`define OP_LUI    7'b0110111
`define OP_BRANCH 7'b1100011
`define OP_JALR   7'b1100111
`define OP_JAL    7'b1101111

// funct7 pattern that selects sub and sra
`define F7_ALT    7'b0100000

`endif

//--- rtl/rvPkg.sv
// RV32I decode types
`default_nettype none

package rvPkg;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } instrWordT;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SUB   = 4'b0001,
        ALU_SLL   = 4'b0010,
        ALU_SLT   = 4'b0011,
        ALU_SLTU  = 4'b0100,
        ALU_XOR   = 4'b0101,
        ALU_SRL   = 4'b0110,
        ALU_SRA   = 4'b0111,
        ALU_OR    = 4'b1000,
        ALU_AND   = 4'b1001,
        ALU_PASSB = 4'b1010,  // lui
        ALU_BAD   = 4'b1111
    } aluOpT;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU   = 2'b00,
        WB_MEM   = 2'b01,
        WB_PC4   = 2'b10,
        WB_PCIMM = 2'b11
    } wbSelT;

    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd3
    } memLenT;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } immKindT;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl or sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store widths
    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;

endpackage

`default_nettype wire

//--- rtl/ctrlIf.sv
// Decoded control bundle
`timescale 1ns/1ns
`default_nettype none

interface ctrlIf
    import rvPkg::*;
(
    input logic clk     // Sampling clock for decoder checks
);
    wbSelT       wbSel;
    logic        memWrite;
    logic        branch;
    logic        jmp;         // jal or jalr
    logic        jalr;
    aluOpT       aluControl;
    logic        aluSrc;      // 1 selects the immediate
    logic        regWrite;
    memLenT      dataLen;
    logic        dataSign;
    immKindT     immKind;
    logic [2:0]  func3;

    modport dec (
        input  clk,
        output wbSel, memWrite, branch, jmp, jalr, aluControl,
        output aluSrc, regWrite, dataLen, dataSign, immKind, func3
    );

    modport exe (
        input wbSel, memWrite, branch, jmp, jalr, aluControl,
        input aluSrc, regWrite, dataLen, dataSign, immKind, func3
    );

endinterface

`default_nettype wire

//--- rtl/controller.sv
// RV32I control decoder
`timescale 1ns/1ns
`default_nettype none
`include "rvDefs.svh"

module controller
    import rvPkg::*;
(
    input instrWordT instr,
    ctrlIf.dec       ctl
);
    logic [6:0] opcode;
    logic [2:0] func3;
    logic       altFunc;
    logic       aluExpected;

    // Arithmetic op from func3, sub only exists for register operands
    function automatic aluOpT decodeFunc(
        input logic [2:0] f3,
        input logic       alt,
        input logic       isReg
    );
        case (f3)
            F3_ADD:  decodeFunc = (alt && isReg) ? ALU_SUB : ALU_ADD;
            F3_SLL:  decodeFunc = ALU_SLL;
            F3_SLT:  decodeFunc = ALU_SLT;
            F3_SLTU: decodeFunc = ALU_SLTU;
            F3_XOR:  decodeFunc = ALU_XOR;
            F3_SR:   decodeFunc = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   decodeFunc = ALU_OR;
            F3_AND:  decodeFunc = ALU_AND;
            default: decodeFunc = ALU_BAD;
        endcase
    endfunction

    assign opcode  = instr.rType.opcode;
    assign func3   = instr.rType.funct3;
    assign altFunc = (instr.rType.funct7 == `F7_ALT);  // Also imm[11:5] for srai

    always_comb begin
        ctl.wbSel      = WB_ALU;
        ctl.memWrite   = 1'b0;
        ctl.branch     = 1'b0;
        ctl.jmp        = 1'b0;
        ctl.jalr       = 1'b0;
        ctl.aluControl = ALU_BAD;
        ctl.aluSrc     = 1'b0;
        ctl.regWrite   = 1'b0;
        ctl.immKind    = IMM_I;
        case (opcode)
            `OP_LOAD: begin
                ctl.wbSel      = WB_MEM;
                ctl.aluControl = ALU_ADD;    // Address
                ctl.aluSrc     = 1'b1;
                ctl.regWrite   = 1'b1;
            end
            `OP_STORE: begin
                ctl.memWrite   = 1'b1;
                ctl.aluControl = ALU_ADD;
                ctl.aluSrc     = 1'b1;
                ctl.immKind    = IMM_S;
            end
            `OP_IMM: begin
                ctl.aluControl = decodeFunc(func3, altFunc, 1'b0);
                ctl.aluSrc     = 1'b1;
                ctl.regWrite   = 1'b1;
            end
            `OP_REG: begin
                ctl.aluControl = decodeFunc(func3, altFunc, 1'b1);
                ctl.regWrite   = 1'b1;
            end
            `OP_BRANCH: begin
                ctl.branch  = 1'b1;    // Compare runs beside the ALU
                ctl.immKind = IMM_B;
            end
            `OP_JAL: begin
                ctl.wbSel    = WB_PC4;
                ctl.jmp      = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.immKind  = IMM_J;
            end
            `OP_JALR: begin
                // Target comes out of the ALU as rs1 + imm
                ctl.wbSel      = WB_PC4;
                ctl.jmp        = 1'b1;
                ctl.jalr       = 1'b1;
                ctl.aluControl = ALU_ADD;
                ctl.aluSrc     = 1'b1;
                ctl.regWrite   = 1'b1;
            end
            `OP_LUI: begin
                ctl.aluControl = ALU_PASSB;
                ctl.aluSrc     = 1'b1;
                ctl.regWrite   = 1'b1;
                ctl.immKind    = IMM_U;
            end
            `OP_AUIPC: begin
                ctl.wbSel      = WB_PCIMM;
                ctl.aluControl = ALU_ADD;
                ctl.regWrite   = 1'b1;
                ctl.immKind    = IMM_U;
            end
            default: ;
        endcase
    end

    // Access width follows func3 for loads and stores alike
    always_comb begin
        case (func3)
            F3_LB, F3_LBU: ctl.dataLen = LEN_BYTE;
            F3_LH, F3_LHU: ctl.dataLen = LEN_HALF;
            F3_LW:         ctl.dataLen = LEN_WORD;
            default:       ctl.dataLen = LEN_WORD;
        endcase
    end

    assign ctl.dataSign = (opcode == `OP_LOAD) && (func3 == F3_LB || func3 == F3_LH);
    assign ctl.func3    = func3;

    assign aluExpected = opcode inside {`OP_LOAD, `OP_IMM, `OP_STORE, `OP_REG,
                                        `OP_JALR, `OP_LUI, `OP_AUIPC};

    // Only branches, jal and unknown opcodes leave the ALU undefined
    aluDecoded: assert property (@(posedge ctl.clk) disable iff ($isunknown(instr))
        aluExpected |-> ctl.aluControl != ALU_BAD);

    noWriteClash: assert property (@(posedge ctl.clk) disable iff ($isunknown(instr))
        !(ctl.memWrite && ctl.regWrite));

endmodule

`default_nettype wire

//--- rtl/immGen.sv
// Immediate generator
`timescale 1ns/1ns
`default_nettype none
`include "rvDefs.svh"

module immGen
    import rvPkg::*;
(
    input  instrWordT        instr,
    input  immKindT          kind,
    output logic [`XLEN-1:0] imm
);
    always_comb begin
        case (kind)
            IMM_I: imm = {{(`XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};
            IMM_S: begin
                imm = {{(`XLEN-12){instr.sType.immHi[6]}},
                       instr.sType.immHi,
                       instr.sType.immLo};
            end
            // Branch offsets are in halfwords
            IMM_B: begin
                imm = {{(`XLEN-13){instr.bType.imm12}},
                       instr.bType.imm12,
                       instr.bType.imm11,
                       instr.bType.imm10to5,
                       instr.bType.imm4to1,
                       1'b0};
            end
            IMM_U: imm = {instr.uType.imm, 12'b0};   // Upper 20 bits
            IMM_J: begin
                imm = {{(`XLEN-21){instr.jType.imm20}},
                       instr.jType.imm20,
                       instr.jType.imm19to12,
                       instr.jType.imm11,
                       instr.jType.imm10to1,
                       1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
// Integer ALU and branch compare
`timescale 1ns/1ns
`default_nettype none
`include "rvDefs.svh"

module alu
    import rvPkg::*;
(
    ctrlIf.exe               ctl,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] result,
    output logic             taken
);
    logic [`SHAMTW-1:0] shamt;
    logic               eq;
    logic               ltSigned;
    logic               ltUnsigned;

    assign shamt      = b[`SHAMTW-1:0];
    assign eq         = (a == b);
    assign ltSigned   = ($signed(a) < $signed(b));
    assign ltUnsigned = (a < b);

    always_comb begin
        case (ctl.aluControl)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_SLL:   result = a << shamt;
            ALU_SLT:   result = {{(`XLEN-1){1'b0}}, ltSigned};
            ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, ltUnsigned};
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = $signed(a) >>> shamt;   // Keeps sign bit
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    // Condition only, the branch flag qualifies it upstream
    always_comb begin
        case (ctl.func3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = !eq;
            F3_BLT:  taken = ltSigned;
            F3_BGE:  taken = !ltSigned;
            F3_BLTU: taken = ltUnsigned;
            F3_BGEU: taken = !ltUnsigned;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/execUnit.sv
// RV32I execute stage
`timescale 1ns/1ns
`default_nettype none
`include "rvDefs.svh"

module execUnit
    import rvPkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    input  logic             req,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    output logic             ack,
    output logic [`XLEN-1:0] rdValue,
    output logic [`XLEN-1:0] nextPc,
    output logic             regWrite,
    output logic             memWrite,
    output logic             memRead,
    output logic [1:0]       dataLen,
    output logic             dataSign,
    output logic             illegal
);
    typedef enum logic {IDLE, DONE} hsStateT;

    hsStateT          state;
    instrWordT        iw;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcPlusImm;
    logic [`XLEN-1:0] rdNext;
    logic [`XLEN-1:0] pcNext;
    logic             taken;
    logic             legalOp;
    logic             capture;

    ctrlIf ctl (.clk(clk));

    controller iCtrl (.instr(iw), .ctl(ctl.dec));
    immGen     iImm  (.instr(iw), .kind(ctl.immKind), .imm(imm));
    alu        iAlu  (.ctl(ctl.exe), .a(rs1Val), .b(aluB), .result(aluResult), .taken(taken));

    assign iw        = instr;
    assign aluB      = ctl.aluSrc ? imm : rs2Val;
    assign pcPlus4   = pc + 4;
    assign pcPlusImm = pc + imm;
    assign legalOp   = iw.rType.opcode inside {`OP_LOAD, `OP_IMM, `OP_STORE, `OP_BRANCH,
                                               `OP_REG, `OP_JAL, `OP_JALR, `OP_LUI,
                                               `OP_AUIPC};

    // Loads and stores return the address from the ALU
    always_comb begin
        case (ctl.wbSel)
            WB_PC4:   rdNext = pcPlus4;
            WB_PCIMM: rdNext = pcPlusImm;
            default:  rdNext = aluResult;
        endcase
    end

    always_comb begin
        if (ctl.jalr) begin
            pcNext = {aluResult[`XLEN-1:1], 1'b0};
        end else if (ctl.jmp || (ctl.branch && taken)) begin
            pcNext = pcPlusImm;
        end else begin
            pcNext = pcPlus4;
        end
    end

    // Four-phase handshake, DONE is the ack phase
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (req) state <= DONE;
                DONE:    if (!req) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign ack     = (state == DONE);
    assign capture = (state == IDLE) && req;   // Results load as ack rises

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWrite <= 1'b0;
            memWrite <= 1'b0;
            memRead  <= 1'b0;
            illegal  <= 1'b0;
        end else if (capture) begin
            regWrite <= ctl.regWrite && legalOp;
            memWrite <= ctl.memWrite && legalOp;
            memRead  <= (ctl.wbSel == WB_MEM) && legalOp;
            illegal  <= !legalOp;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdValue  <= rdNext;
            nextPc   <= pcNext;
            dataLen  <= ctl.dataLen;
            dataSign <= ctl.dataSign;
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req));

    // Host may hold req as long as it likes
    outputsHeld: assert property (@(posedge clk) disable iff (!rstN)
        ack && $past(ack) |-> $stable({rdValue, nextPc, regWrite, memWrite,
                                       memRead, dataLen, dataSign, illegal}));

endmodule

`default_nettype wire

//--- test/execUnitTb.sv
// Execute stage testbench
`timescale 1ns/1ns
`default_nettype none
`include "rvDefs.svh"

module execUnitTb;
    localparam int TIMEOUT = 50;    // Cycles per handshake phase

    logic             clk;
    logic             rstN;
    logic             req;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic             ack;
    logic [`XLEN-1:0] rdValue;
    logic [`XLEN-1:0] nextPc;
    logic             regWrite;
    logic             memWrite;
    logic             memRead;
    logic [1:0]       dataLen;
    logic             dataSign;
    logic             illegal;

    // Reference model results for the instruction in flight
    logic [`XLEN-1:0] expRd;
    logic [`XLEN-1:0] expPc;
    logic             expRegWr;
    logic             expMemWr;
    logic             expMemRd;
    logic [1:0]       expLen;
    logic             expSign;
    logic             expIllegal;
    logic             chkRd;        // rdValue is defined
    logic             chkLen;       // Memory access

    int seed;
    int errCount;
    int passCount;
    int failCount;

    execUnit i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .instr    (instr),
        .pc       (pc),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .ack      (ack),
        .rdValue  (rdValue),
        .nextPc   (nextPc),
        .regWrite (regWrite),
        .memWrite (memWrite),
        .memRead  (memRead),
        .dataLen  (dataLen),
        .dataSign (dataSign),
        .illegal  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic flagMismatch(input string name, input logic [`XLEN-1:0] exp,
                                input logic [`XLEN-1:0] act);
        $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
        errCount++;
    endtask

    task automatic flagError(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errCount++;
    endtask

    task automatic abortRun(input string why);
        $display("TIMEOUT t=%0t %s", $time, why);
        $display("=== FAIL ===");
        $finish;
    endtask

    function automatic logic [`XLEN-1:0] randWord();
        randWord = $random(seed);
    endfunction

    function automatic logic [`XLEN-1:0] randPc();
        randPc = randWord() & 32'hffff_fffc;   // Word aligned
    endfunction

    // Instruction encoders, rd = x5, rs1 = x6, rs2 = x7
    function automatic logic [`XLEN-1:0] encR(input logic [6:0] f7, input logic [2:0] f3);
        encR = {f7, 5'd7, 5'd6, f3, 5'd5, `OP_REG};
    endfunction

    function automatic logic [`XLEN-1:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                              input logic [6:0] op);
        encI = {imm, 5'd6, f3, 5'd5, op};
    endfunction

    function automatic logic [`XLEN-1:0] encS(input logic [11:0] imm, input logic [2:0] f3);
        encS = {imm[11:5], 5'd7, 5'd6, f3, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [`XLEN-1:0] encB(input logic [12:0] imm, input logic [2:0] f3);
        encB = {imm[12], imm[10:5], 5'd7, 5'd6, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [`XLEN-1:0] encU(input logic [19:0] imm, input logic [6:0] op);
        encU = {imm, 5'd5, op};
    endfunction

    function automatic logic [`XLEN-1:0] encJ(input logic [20:0] imm);
        encJ = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd5, `OP_JAL};
    endfunction

    // ISA arithmetic, sub exists only in the register form
    function automatic logic [`XLEN-1:0] arith(input logic [2:0] f3, input logic alt,
                                               input logic isReg, input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    arith = (alt && isReg) ? a - b : a + b;
            3'd1:    arith = a << sh;
            3'd2:    arith = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    arith = (a < b) ? 32'd1 : 32'd0;
            3'd4:    arith = a ^ b;
            3'd5:    arith = alt ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6:    arith = a | b;
            default: arith = a & b;
        endcase
    endfunction

    function automatic logic branchHolds(input logic [2:0] f3, input logic [`XLEN-1:0] a,
                                         input logic [`XLEN-1:0] b);
        case (f3)
            3'd0:    branchHolds = (a == b);
            3'd1:    branchHolds = (a != b);
            3'd4:    branchHolds = ($signed(a) < $signed(b));
            3'd5:    branchHolds = ($signed(a) >= $signed(b));
            3'd6:    branchHolds = (a < b);
            3'd7:    branchHolds = (a >= b);
            default: branchHolds = 1'b0;
        endcase
    endfunction

    task automatic predict(input logic [`XLEN-1:0] ins, input logic [`XLEN-1:0] pcIn,
                           input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        logic [6:0]       op;
        logic [2:0]       f3;
        logic [`XLEN-1:0] immI;
        logic [`XLEN-1:0] immS;
        logic [`XLEN-1:0] immB;
        logic [`XLEN-1:0] immU;
        logic [`XLEN-1:0] immJ;
        op   = ins[6:0];
        f3   = ins[14:12];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'b0};
        immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        expRd      = '0;
        expPc      = pcIn + 32'd4;
        expRegWr   = 1'b0;
        expMemWr   = 1'b0;
        expMemRd   = 1'b0;
        expLen     = (f3[1:0] == 2'd0) ? 2'd0 : (f3[1:0] == 2'd1) ? 2'd1 : 2'd3;
        expSign    = 1'b0;
        expIllegal = 1'b0;
        chkRd      = 1'b0;
        chkLen     = 1'b0;
        case (op)
            `OP_REG: begin
                expRd    = arith(f3, ins[30], 1'b1, a, b);
                expRegWr = 1'b1;
                chkRd    = 1'b1;
            end
            `OP_IMM: begin
                expRd    = arith(f3, ins[30], 1'b0, a, immI);
                expRegWr = 1'b1;
                chkRd    = 1'b1;
            end
            `OP_LOAD: begin
                expRd    = a + immI;     // Address
                expRegWr = 1'b1;
                expMemRd = 1'b1;
                expSign  = (f3 == 3'd0 || f3 == 3'd1);
                chkRd    = 1'b1;
                chkLen   = 1'b1;
            end
            `OP_STORE: begin
                expRd    = a + immS;
                expMemWr = 1'b1;
                chkRd    = 1'b1;
                chkLen   = 1'b1;
            end
            `OP_BRANCH: if (branchHolds(f3, a, b)) expPc = pcIn + immB;
            `OP_JAL: begin
                expRd    = pcIn + 32'd4;
                expPc    = pcIn + immJ;
                expRegWr = 1'b1;
                chkRd    = 1'b1;
            end
            `OP_JALR: begin
                expRd    = pcIn + 32'd4;
                expPc    = (a + immI) & 32'hffff_fffe;
                expRegWr = 1'b1;
                chkRd    = 1'b1;
            end
            `OP_LUI: begin
                expRd    = immU;
                expRegWr = 1'b1;
                chkRd    = 1'b1;
            end
            `OP_AUIPC: begin
                expRd    = pcIn + immU;
                expRegWr = 1'b1;
                chkRd    = 1'b1;
            end
            default: expIllegal = 1'b1;
        endcase
    endtask

    // One full four-phase transfer, hold keeps req high after ack
    task automatic runCase(input logic [`XLEN-1:0] ins, input logic [`XLEN-1:0] pcIn,
                           input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                           input int hold);
        int cycles;
        predict(ins, pcIn, a, b);
        @(posedge clk);
        instr  <= ins;
        pc     <= pcIn;
        rs1Val <= a;
        rs2Val <= b;
        req    <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < TIMEOUT);
        if (!ack) abortRun("ack never rose after req");
        repeat (hold) @(posedge clk);
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack && cycles < TIMEOUT);
        if (ack) abortRun("ack never fell after req dropped");
    endtask

    task automatic endTest(input string name, input int errsBefore);
        if (errCount == errsBefore) begin
            passCount++;
            $display("test %-10s ok", name);
        end else begin
            failCount++;
            $display("test %-10s failed with %0d errors", name, errCount - errsBefore);
        end
    endtask

    task automatic rTypeTest();
        logic [6:0] f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        int errs;
        errs = errCount;
        for (int i = 0; i < 10; i++) begin
            for (int k = 0; k < 3; k++) begin
                runCase(encR(f7s[i], f3s[i]), randPc(), randWord(), randWord(), 0);
            end
        end
        endTest("R-type", errs);
    endtask

    task automatic iTypeTest();
        logic [2:0] f3s [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        logic [4:0] sh;
        int         errs;
        errs = errCount;
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 3; k++) begin
                runCase(encI(12'(randWord()), f3s[i], `OP_IMM), randPc(), randWord(), 0, 0);
            end
        end
        // Immediate sign edges
        runCase(encI(12'h800, 3'd0, `OP_IMM), randPc(), randWord(), 0, 0);
        runCase(encI(12'h7ff, 3'd3, `OP_IMM), randPc(), 32'hffff_f000, 0, 0);
        for (int k = 0; k < 3; k++) begin
            sh = 5'(randWord());
            runCase(encI({7'h00, sh}, 3'd1, `OP_IMM), randPc(), randWord(), 0, 0);
            runCase(encI({7'h00, sh}, 3'd5, `OP_IMM), randPc(), randWord(), 0, 0);
            runCase(encI({7'h20, sh}, 3'd5, `OP_IMM), randPc(), randWord() | 32'h8000_0000,
                    0, 0);
        end
        endTest("I-type", errs);
    endtask

    task automatic memTest();
        logic [2:0] loads [5]  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        logic [2:0] stores [3] = '{3'd0, 3'd1, 3'd2};
        int         errs;
        errs = errCount;
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 5; i++) begin
                runCase(encI(12'(randWord()), loads[i], `OP_LOAD), randPc(), randWord(),
                        randWord(), 0);
            end
            for (int i = 0; i < 3; i++) begin
                runCase(encS(12'(randWord()), stores[i]), randPc(), randWord(), randWord(), 0);
            end
        end
        endTest("load/store", errs);
    endtask

    task automatic branchTest();
        logic [2:0]       conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [`XLEN-1:0] as [5];
        logic [`XLEN-1:0] bs [5];
        logic [`XLEN-1:0] same;
        logic [12:0]      off;
        int               errs;
        errs = errCount;
        same = randWord();
        // Equal pair, then pairs where signed and unsigned order disagree
        as = '{same, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0001};
        bs = '{same, 32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001, 32'hffff_ffff};
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 5; k++) begin
                off = 13'(randWord()) & 13'h1ffe;
                runCase(encB(off, conds[i]), randPc(), as[k], bs[k], 0);
            end
        end
        endTest("branch", errs);
    endtask

    task automatic jumpTest();
        int errs;
        errs = errCount;
        for (int k = 0; k < 3; k++) begin
            runCase(encJ(21'(randWord()) & 21'h1ffffe), randPc(), randWord(), randWord(), 0);
            // Odd target so bit 0 must be cleared
            runCase(encI(12'(randWord()) | 12'h001, 3'd0, `OP_JALR), randPc(),
                    randWord() & 32'hffff_fffe, randWord(), 0);
            runCase(encU(20'(randWord()), `OP_LUI), randPc(), randWord(), randWord(), 0);
            runCase(encU(20'(randWord()), `OP_AUIPC), randPc(), randWord(), randWord(), 0);
        end
        runCase(encI(12'(randWord()), 3'd0, 7'h7f), randPc(), randWord(), randWord(), 0);
        runCase(encI(12'(randWord()), 3'd0, 7'h73), randPc(), randWord(), randWord(), 0);
        runCase(encI(12'(randWord()), 3'd0, 7'h0f), randPc(), randWord(), randWord(), 0);
        endTest("jump/upper", errs);
    endtask

    task automatic handshakeTest();
        int errs;
        errs = errCount;
        runCase(encI(12'(randWord()), 3'd0, `OP_IMM), randPc(), randWord(), 0, 20);
        runCase(encS(12'(randWord()), 3'd2), randPc(), randWord(), randWord(), 20);
        runCase(encI(12'(randWord()), 3'd4, `OP_LOAD), randPc(), randWord(), 0, 0);
        endTest("handshake", errs);
    endtask

    // Output values, checked one cycle after ack rises
    rdCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) && chkRd |-> rdValue == expRd)
        else flagMismatch("rdValue", expRd, rdValue);
    pcCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> nextPc == expPc)
        else flagMismatch("nextPc", expPc, nextPc);
    regWrCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> regWrite == expRegWr)
        else flagMismatch("regWrite", 32'(expRegWr), 32'(regWrite));
    memWrCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> memWrite == expMemWr)
        else flagMismatch("memWrite", 32'(expMemWr), 32'(memWrite));
    memRdCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> memRead == expMemRd)
        else flagMismatch("memRead", 32'(expMemRd), 32'(memRead));
    lenCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) && chkLen |-> dataLen == expLen)
        else flagMismatch("dataLen", 32'(expLen), 32'(dataLen));
    signCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> dataSign == expSign)
        else flagMismatch("dataSign", 32'(expSign), 32'(dataSign));
    illegalCheck: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> illegal == expIllegal)
        else flagMismatch("illegal", 32'(expIllegal), 32'(illegal));

    resetClear: assert property (@(posedge clk)
        !rstN |-> !ack && !regWrite && !memWrite)
        else flagMismatch("{ack,regWrite,memWrite}", 0, 32'({ack, regWrite, memWrite}));

    // Handshake timing
    ackNotEarly: assert property (@(posedge clk) disable iff (!rstN)
        $rose(req) |-> !ack)
        else flagError("ack was already high when req rose");
    ackOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        $rose(req) |=> ack)
        else flagError("ack did not rise one cycle after req");
    ackHeld: assert property (@(posedge clk) disable iff (!rstN)
        ack && req |=> ack)
        else flagError("ack dropped while req was still high");
    ackFalls: assert property (@(posedge clk) disable iff (!rstN)
        $fell(req) |=> !ack)
        else flagError("ack did not fall at the first edge with req low");
    outsStable: assert property (@(posedge clk) disable iff (!rstN)
        ack && $past(ack) |-> $stable({rdValue, nextPc, regWrite, memWrite, memRead,
                                       dataLen, dataSign, illegal}))
        else flagError("outputs changed while ack was high");

    initial begin
        int errs;
        seed      = 62229;
        errCount  = 0;
        passCount = 0;
        failCount = 0;
        rstN      = 1'b1;
        req       = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1Val    = '0;
        rs2Val    = '0;
        errs      = errCount;
        @(posedge clk);
        rstN <= 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        endTest("reset", errs);

        rTypeTest();
        iTypeTest();
        memTest();
        branchTest();
        jumpTest();
        handshakeTest();

        $display("tests passed %0d, failed %0d, check errors %0d",
                 passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/rvPkg.sv
rtl/ctrlIf.sv
rtl/controller.sv
rtl/immGen.sv
rtl/alu.sv
rtl/execUnit.sv
test/execUnitTb.sv

//--- Makefile
SIM      = verilator
TOP      = execUnitTb
FILELIST = project.f
FLAGS    = --binary --timing --assert -j 0
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
